//--- risc8_pkg.sv
// shared types and constants for the risc8 core; 16-bit PC only, I/O window fixed at 0x20
package risc8_pkg;

	// basic widths
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	localparam int REG_SEL_W = 5;
	localparam int IO_ADDR_W = 6;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [REG_SEL_W-1:0] reg_sel_t;

	// ALU operations
	// move passes a register, movr passes the constant operand
	// cmp subtracts without a write back
	typedef enum logic [3:0] {
		ALU_MOVE,
		ALU_MOVR,
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_CMP
	} alu_op_t;

	// instruction classes seen by the control unit
	typedef enum logic [2:0] {
		INSTR_ALU,
		INSTR_COM,
		INSTR_OUT,
		INSTR_IN,
		INSTR_RJMP,
		INSTR_BRB,
		INSTR_NOP
	} instr_t;

	// I/O address plus this offset gives the data address
	localparam word_t IO_BASE = 16'h0020;
	// status register lives inside the core at this I/O address
	localparam logic [IO_ADDR_W-1:0] IO_SREG = 6'h3F;

	// SREG bit positions, only these four are kept
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;

	localparam word_t PC_RESET = 16'h0000;

endpackage

//--- risc8_decode.sv
// opcode classifier for the trimmed AVR subset; anything not listed decodes as a no-op
`timescale 1ns/1ns

module risc8_decode import risc8_pkg::*; (
	input word_t opcode,
	output instr_t instr,
	output alu_op_t alu_op,
	output logic alu_carry,
	output logic alu_store,
	output logic alu_imm,
	output reg_sel_t rd,
	output reg_sel_t rr,
	output byte_t k_value,
	output logic [IO_ADDR_W-1:0] io_addr,
	output logic [2:0] bit_select,
	output logic bit_set,
	output word_t simm12,
	output word_t simm7
);

	// fixed field positions
	assign io_addr = {opcode[10:9], opcode[3:0]};
	assign bit_select = opcode[2:0];
	// BRBS has bit 10 clear, BRBC has it set
	assign bit_set = ~opcode[10];
	assign simm12 = {{4{opcode[11]}}, opcode[11:0]};
	assign simm7 = {{9{opcode[9]}}, opcode[9:3]};

	always_comb begin
		instr = INSTR_NOP;
		alu_op = ALU_MOVE;
		alu_carry = 1'b0;
		alu_store = 1'b0;
		alu_imm = 1'b0;
		rd = opcode[8:4];
		rr = {opcode[9], opcode[3:0]};
		k_value = {opcode[11:8], opcode[3:0]};

		casez (opcode)
		// register-register group
		16'b0000_01??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_CMP;
			alu_carry = 1'b1;
		end
		16'b0000_10??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_SBC;
			alu_carry = 1'b1;
			alu_store = 1'b1;
		end
		16'b0000_11??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_ADD;
			alu_store = 1'b1;
		end
		16'b0001_01??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_CMP;
		end
		16'b0001_10??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_SUB;
			alu_store = 1'b1;
		end
		16'b0001_11??_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_ADC;
			alu_carry = 1'b1;
			alu_store = 1'b1;
		end
		16'b0010_????_????_????: begin
			instr = INSTR_ALU;
			alu_store = 1'b1;
			// AND, EOR, OR, MOV in bits 11:10
			case (opcode[11:10])
			2'b00: alu_op = ALU_AND;
			2'b01: alu_op = ALU_EOR;
			2'b10: alu_op = ALU_OR;
			default: alu_op = ALU_MOVE;
			endcase
		end
		// immediate group, CPI does not write
		16'b0011_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_CMP;
			alu_imm = 1'b1;
		end
		16'b0100_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_SBC;
			alu_carry = 1'b1;
			alu_store = 1'b1;
			alu_imm = 1'b1;
		end
		16'b0101_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_SUB;
			alu_store = 1'b1;
			alu_imm = 1'b1;
		end
		16'b0110_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_OR;
			alu_store = 1'b1;
			alu_imm = 1'b1;
		end
		16'b0111_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_AND;
			alu_store = 1'b1;
			alu_imm = 1'b1;
		end
		16'b1110_????_????_????: begin
			instr = INSTR_ALU;
			alu_op = ALU_MOVR;
			alu_store = 1'b1;
			alu_imm = 1'b1;
		end
		// COM Rd runs as Rd ^ 0xff on any register
		16'b1001_010?_????_0000: begin
			instr = INSTR_COM;
			alu_op = ALU_EOR;
			alu_store = 1'b1;
			alu_imm = 1'b1;
			k_value = 8'hFF;
		end
		16'b1011_0???_????_????: instr = INSTR_IN;
		16'b1011_1???_????_????: instr = INSTR_OUT;
		16'b1100_????_????_????: instr = INSTR_RJMP;
		16'b1111_0???_????_????: instr = INSTR_BRB;
		default: instr = INSTR_NOP;
		endcase

		// immediate forms only reach r16..r31
		if (alu_imm && instr == INSTR_ALU)
			rd = {1'b1, opcode[7:4]};
	end

endmodule

//--- risc8_regs.sv
// 32x8 flop register file; reads land one cycle after the select, same-edge writes forward
`timescale 1ns/1ns

module risc8_regs import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_sel_t sel_a,
	input reg_sel_t sel_b,
	output byte_t ra,
	output byte_t rb,
	input reg_sel_t sel_d,
	input byte_t wdata,
	input logic write
);

	byte_t mem [NUM_REGS];

	// write port
	always_ff @(posedge clk) begin
		if (write)
			mem[sel_d] <= wdata;
	end

	// registered read ports
	// a write to the same register in this cycle wins over the array
	always_ff @(posedge clk) begin
		if (reset) begin
			ra <= '0;
			rb <= '0;
		end else begin
			if (write && sel_d == sel_a)
				ra <= wdata;
			else
				ra <= mem[sel_a];

			if (write && sel_d == sel_b)
				rb <= wdata;
			else
				rb <= mem[sel_b];
		end
	end

endmodule

//--- risc8_alu.sv
// 8-bit ALU for the kept AVR ops; only C, Z, N and V are produced, other SREG bits pass through
`timescale 1ns/1ns

module risc8_alu import risc8_pkg::*; (
	input alu_op_t op,
	input logic use_carry,
	input byte_t rd_in,
	input byte_t rr_in,
	input byte_t sreg_in,
	output byte_t r_out,
	output byte_t sreg_out
);

	logic carry_in;
	logic [BYTE_W:0] sum;
	logic [BYTE_W:0] diff;
	logic zero;

	always_comb begin
		// ADC, SBC, CPC and SBCI chain the old carry
		carry_in = use_carry & sreg_in[SREG_C];
		sum = {1'b0, rd_in} + {1'b0, rr_in} + {{BYTE_W{1'b0}}, carry_in};
		// bit 8 of the difference is the borrow
		diff = {1'b0, rd_in} - {1'b0, rr_in} - {{BYTE_W{1'b0}}, carry_in};

		r_out = rr_in;
		sreg_out = sreg_in;

		case (op)
		ALU_ADD, ALU_ADC: begin
			r_out = sum[7:0];
			sreg_out[SREG_C] = sum[8];
			// both operands share a sign that the result lost
			sreg_out[SREG_V] = (rd_in[7] & rr_in[7] & ~r_out[7])
				| (~rd_in[7] & ~rr_in[7] & r_out[7]);
		end
		ALU_SUB, ALU_SBC, ALU_CMP: begin
			r_out = diff[7:0];
			sreg_out[SREG_C] = diff[8];
			sreg_out[SREG_V] = (rd_in[7] & ~rr_in[7] & ~r_out[7])
				| (~rd_in[7] & rr_in[7] & r_out[7]);
		end
		ALU_AND: begin
			r_out = rd_in & rr_in;
			sreg_out[SREG_V] = 1'b0;
		end
		ALU_OR: begin
			r_out = rd_in | rr_in;
			sreg_out[SREG_V] = 1'b0;
		end
		ALU_EOR: begin
			r_out = rd_in ^ rr_in;
			sreg_out[SREG_V] = 1'b0;
		end
		// move and movr pass the second operand untouched
		default: r_out = rr_in;
		endcase

		zero = r_out == 8'h00;

		// N and Z follow the result on every flag-setting op
		if (op != ALU_MOVE && op != ALU_MOVR) begin
			sreg_out[SREG_N] = r_out[7];
			sreg_out[SREG_Z] = zero;
			// multi-byte subtract keeps Z only while every byte was zero
			if (use_carry && (op == ALU_SUB || op == ALU_SBC || op == ALU_CMP))
				sreg_out[SREG_Z] = zero & sreg_in[SREG_Z];
		end
	end

endmodule

//--- risc8_control.sv
// PC, SREG and stage-two control; IN/OUT use one extra cycle, the I/O bus never stalls
`timescale 1ns/1ns

module risc8_control import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t cdata,
	input instr_t instr,
	input alu_op_t alu_op,
	input logic alu_carry,
	input logic alu_store,
	input logic alu_imm,
	input reg_sel_t rd,
	input reg_sel_t rr,
	input byte_t k_value,
	input logic [IO_ADDR_W-1:0] io_addr,
	input logic [2:0] bit_select,
	input logic bit_set,
	input word_t simm12,
	input word_t simm7,
	input byte_t ra,
	input byte_t rb,
	input byte_t alu_result,
	input byte_t sreg_next,
	output word_t opcode,
	output reg_sel_t sel_a,
	output reg_sel_t sel_b,
	output reg_sel_t sel_d,
	output logic reg_write,
	output byte_t wdata,
	output alu_op_t alu_op_q,
	output logic carry_q,
	output byte_t operand_b,
	output byte_t sreg,
	output word_t pc,
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	input byte_t data_read,
	output byte_t data_write
);

	word_t pc_q;
	word_t next_pc;
	word_t prev_opcode;
	// low until the first fetch after reset has landed
	logic run;
	logic cycle;
	logic next_cycle;
	logic is_sreg;

	// stage-two registers
	logic store_q;
	logic imm_q;
	byte_t const_q;
	reg_sel_t dest_q;

	// stage-one results headed for stage two
	alu_op_t op_d;
	logic carry_d;
	logic store_d;
	logic imm_d;
	byte_t const_d;
	byte_t sreg_d;

	// second cycle of IN/OUT replays the held opcode
	assign opcode = cycle ? prev_opcode : cdata;
	assign is_sreg = io_addr == IO_SREG;

	// Rd on port a, Rr on port b
	assign sel_a = rd;
	assign sel_b = rr;

	// write back happens in stage two
	assign sel_d = dest_q;
	assign reg_write = store_q;
	assign wdata = alu_result;
	assign operand_b = imm_q ? const_q : rb;

	// fetch address for the next cycle
	assign pc = next_pc;

	// I/O bus address and data follow the current opcode
	assign data_addr = IO_BASE + word_t'(io_addr);
	assign data_write = ra;

	always_comb begin
		next_pc = pc_q + 16'd1;
		next_cycle = 1'b0;
		op_d = ALU_MOVE;
		carry_d = 1'b0;
		store_d = 1'b0;
		imm_d = 1'b0;
		const_d = k_value;
		sreg_d = sreg_next;
		data_wen = 1'b0;
		data_ren = 1'b0;

		if (!run) begin
			// cdata not valid yet, keep fetching word 0
			next_pc = pc_q;
		end else begin
			case (instr)
			INSTR_ALU, INSTR_COM: begin
				op_d = alu_op;
				carry_d = alu_carry;
				store_d = alu_store;
				imm_d = alu_imm;
			end
			INSTR_OUT: begin
				// first cycle waits for Rr to show up on ra
				if (!cycle)
					next_cycle = 1'b1;
				else if (is_sreg)
					sreg_d = ra;
				else
					data_wen = 1'b1;
			end
			INSTR_IN: begin
				if (!cycle) begin
					data_ren = 1'b1;
					next_cycle = 1'b1;
				end else begin
					// read data rides stage two as a constant move
					op_d = ALU_MOVR;
					store_d = 1'b1;
					imm_d = 1'b1;
					const_d = is_sreg ? sreg : data_read;
				end
			end
			INSTR_RJMP: next_pc = pc_q + simm12 + 16'd1;
			INSTR_BRB: begin
				// flags of the op now in stage two count
				if (sreg_next[bit_select] == bit_set)
					next_pc = pc_q + simm7 + 16'd1;
			end
			default: begin
				// unsupported, nothing issued
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= PC_RESET;
			run <= 1'b0;
			cycle <= 1'b0;
			sreg <= '0;
			store_q <= 1'b0;
			imm_q <= 1'b0;
			carry_q <= 1'b0;
			alu_op_q <= ALU_MOVE;
		end else begin
			run <= 1'b1;
			cycle <= next_cycle;
			sreg <= sreg_d;
			// pc holds through the first cycle of IN/OUT
			if (!next_cycle)
				pc_q <= next_pc;
			store_q <= store_d;
			imm_q <= imm_d;
			carry_q <= carry_d;
			alu_op_q <= op_d;
		end
	end

	// payload side of the pipeline
	always_ff @(posedge clk) begin
		prev_opcode <= opcode;
		const_q <= const_d;
		dest_q <= rd;
	end

endmodule

//--- risc8_core.sv
// risc8 top level; ROM must return cdata one clock after pc, data bus has no back-pressure
`timescale 1ns/1ns

module risc8_core import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	output word_t pc,
	input word_t cdata,
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	input byte_t data_read,
	output byte_t data_write
);

	// decode outputs
	word_t opcode;
	instr_t instr;
	alu_op_t alu_op;
	logic alu_carry;
	logic alu_store;
	logic alu_imm;
	reg_sel_t rd;
	reg_sel_t rr;
	byte_t k_value;
	logic [IO_ADDR_W-1:0] io_addr;
	logic [2:0] bit_select;
	logic bit_set;
	word_t simm12;
	word_t simm7;

	// register file ports
	reg_sel_t sel_a;
	reg_sel_t sel_b;
	reg_sel_t sel_d;
	byte_t ra;
	byte_t rb;
	logic reg_write;
	byte_t wdata;

	// stage-two ALU path
	alu_op_t alu_op_q;
	logic carry_q;
	byte_t operand_b;
	byte_t sreg;
	byte_t alu_result;
	byte_t sreg_next;

	risc8_decode decode (
		.opcode(opcode),
		.instr(instr),
		.alu_op(alu_op),
		.alu_carry(alu_carry),
		.alu_store(alu_store),
		.alu_imm(alu_imm),
		.rd(rd),
		.rr(rr),
		.k_value(k_value),
		.io_addr(io_addr),
		.bit_select(bit_select),
		.bit_set(bit_set),
		.simm12(simm12),
		.simm7(simm7)
	);

	risc8_regs regs (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.ra(ra),
		.rb(rb),
		.sel_d(sel_d),
		.wdata(wdata),
		.write(reg_write)
	);

	// Rd always comes straight from port a
	risc8_alu alu (
		.op(alu_op_q),
		.use_carry(carry_q),
		.rd_in(ra),
		.rr_in(operand_b),
		.sreg_in(sreg),
		.r_out(alu_result),
		.sreg_out(sreg_next)
	);

	risc8_control control (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.instr(instr),
		.alu_op(alu_op),
		.alu_carry(alu_carry),
		.alu_store(alu_store),
		.alu_imm(alu_imm),
		.rd(rd),
		.rr(rr),
		.k_value(k_value),
		.io_addr(io_addr),
		.bit_select(bit_select),
		.bit_set(bit_set),
		.simm12(simm12),
		.simm7(simm7),
		.ra(ra),
		.rb(rb),
		.alu_result(alu_result),
		.sreg_next(sreg_next),
		.opcode(opcode),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.sel_d(sel_d),
		.reg_write(reg_write),
		.wdata(wdata),
		.alu_op_q(alu_op_q),
		.carry_q(carry_q),
		.operand_b(operand_b),
		.sreg(sreg),
		.pc(pc),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_read(data_read),
		.data_write(data_write)
	);

endmodule

//--- risc8_tb.sv
// directed testbench for risc8_core; each program ends in an RJMP to itself, I/O model is 64 bytes
`timescale 1ns/1ns

module risc8_tb import risc8_pkg::*; ();

	// register-register opcode bases in bits 15:10
	localparam logic [5:0] OP_ADD = 6'b000011;
	localparam logic [5:0] OP_ADC = 6'b000111;
	localparam logic [5:0] OP_SUB = 6'b000110;
	localparam logic [5:0] OP_SBC = 6'b000010;
	localparam logic [5:0] OP_AND = 6'b001000;
	localparam logic [5:0] OP_EOR = 6'b001001;
	localparam logic [5:0] OP_OR = 6'b001010;
	localparam logic [5:0] OP_MOV = 6'b001011;
	localparam logic [5:0] OP_CP = 6'b000101;
	localparam logic [5:0] OP_CPC = 6'b000001;
	// immediate opcode bases in bits 15:12
	localparam logic [3:0] OP_CPI = 4'b0011;
	localparam logic [3:0] OP_SUBI = 4'b0101;
	localparam logic [3:0] OP_ORI = 4'b0110;
	localparam logic [3:0] OP_ANDI = 4'b0111;
	localparam logic [3:0] OP_LDI = 4'b1110;
	localparam word_t HALT = 16'hCFFF;
	// all five programs together
	localparam int TOTAL_WORDS = 80;
	localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 200;

	logic clk;
	logic reset;
	word_t pc;
	word_t cdata;
	word_t data_addr;
	logic data_wen;
	logic data_ren;
	byte_t data_read;
	byte_t data_write;

	word_t rom [256];
	byte_t io_mem [64];
	word_t prog [$];
	word_t wr_addr [$];
	byte_t wr_data [$];
	word_t exp_addr [$];
	byte_t exp_data [$];
	int cycles;

	risc8_core uut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_read(data_read),
		.data_write(data_write)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// program ROM returns one registered word per clock
	always @(posedge clk)
		cdata <= rom[pc[7:0]];

	// I/O model answers a read in the next cycle
	always @(posedge clk) begin
		if (data_ren)
			data_read <= io_mem[6'(data_addr - IO_BASE)];
	end

	// every bus write is logged in order
	always @(posedge clk) begin
		if (data_wen) begin
			if (data_addr == IO_BASE + 16'h003F)
				fail_now("OUT to SREG pulsed data_wen");
			wr_addr.push_back(data_addr);
			wr_data.push_back(data_write);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, program did not finish");
			$display("*** TEST FAILED ***");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string msg);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "word mismatch");
		end
	endtask

	// instruction encoders
	function automatic word_t rr_word(logic [5:0] base, reg_sel_t d, reg_sel_t r);
		return {base, r[4], d, r[3:0]};
	endfunction

	function automatic word_t imm_word(logic [3:0] base, reg_sel_t d, byte_t k);
		return {base, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic word_t com_word(reg_sel_t d);
		return {7'b1001010, d, 4'b0000};
	endfunction

	function automatic word_t in_word(reg_sel_t d, logic [5:0] a);
		return {5'b10110, a[5:4], d, a[3:0]};
	endfunction

	function automatic word_t out_word(logic [5:0] a, reg_sel_t r);
		return {5'b10111, a[5:4], r, a[3:0]};
	endfunction

	function automatic word_t rjmp_word(logic [11:0] k);
		return {4'hC, k};
	endfunction

	// clr high gives BRBC
	function automatic word_t branch_word(logic clr, logic [2:0] s, logic [6:0] k);
		return {5'b11110, clr, k, s};
	endfunction

	// AVR subtract flags where chain keeps Z only if the earlier bytes were zero
	function automatic byte_t sub_flags(byte_t x, byte_t y, logic cin, logic zin, logic chain);
		int t;
		int s;
		byte_t res;
		byte_t f;
		t = int'(x) - int'(y) - int'(cin);
		s = int'($signed(x)) - int'($signed(y)) - int'(cin);
		res = byte_t'(t);
		f = '0;
		f[SREG_C] = t < 0;
		f[SREG_Z] = (res == 8'h00) && (!chain || zin);
		f[SREG_N] = res[7];
		f[SREG_V] = (s < -128) || (s > 127);
		return f;
	endfunction

	task automatic expect_write(logic [5:0] a, byte_t d);
		exp_addr.push_back(IO_BASE + word_t'(a));
		exp_data.push_back(d);
	endtask

	// load prog, reset, run to the halt loop, compare bus writes
	task automatic run_program(input string name);
		for (int i = 0; i < 256; i++)
			rom[i] = (i < prog.size()) ? prog[i] : {8'h00, 8'(i)};
		@(posedge clk);
		reset <= 1'b1;
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_word(pc, PC_RESET, "pc during reset");
		if (data_wen || data_ren)
			fail_now("bus strobe active during reset");
		wr_addr.delete();
		wr_data.delete();
		@(posedge clk);
		reset <= 1'b0;
		do @(negedge clk); while (cdata !== HALT);
		// let a trailing OUT finish its second cycle
		repeat (3) @(negedge clk);
		if (wr_addr.size() != exp_addr.size())
			fail_now($sformatf("%s: %0d bus writes seen, %0d expected",
				name, wr_addr.size(), exp_addr.size()));
		foreach (exp_addr[i]) begin
			check_word(wr_addr[i], exp_addr[i], {name, " write address"});
			check_byte(wr_data[i], exp_data[i], {name, " write data"});
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic ldi_out_test();
		byte_t k;
		for (int i = 0; i < 4; i++) begin
			k = byte_t'($urandom);
			prog.push_back(imm_word(OP_LDI, reg_sel_t'(16 + i), k));
			expect_write(6'(5 + i), k);
		end
		for (int i = 0; i < 4; i++)
			prog.push_back(out_word(6'(5 + i), reg_sel_t'(16 + i)));
		prog.push_back(HALT);
		run_program("ldi/out");
	endtask

	task automatic alu_chain_test();
		byte_t a;
		byte_t b;
		byte_t r;
		byte_t k;
		logic c;
		int t;
		a = byte_t'($urandom);
		b = byte_t'($urandom);
		prog.push_back(imm_word(OP_LDI, 16, a));
		prog.push_back(imm_word(OP_LDI, 17, b));
		r = a;
		// add with and without carry in
		t = int'(r) + int'(b);
		c = t > 255;
		r = byte_t'(t);
		prog.push_back(rr_word(OP_ADD, 16, 17));
		expect_write(1, r);
		t = int'(r) + int'(b) + int'(c);
		c = t > 255;
		r = byte_t'(t);
		prog.push_back(rr_word(OP_ADC, 16, 17));
		expect_write(1, r);
		t = int'(r) - int'(b);
		c = t < 0;
		r = byte_t'(t);
		prog.push_back(rr_word(OP_SUB, 16, 17));
		expect_write(1, r);
		t = int'(r) - int'(b) - int'(c);
		r = byte_t'(t);
		prog.push_back(rr_word(OP_SBC, 16, 17));
		expect_write(1, r);
		r = r & b;
		prog.push_back(rr_word(OP_AND, 16, 17));
		expect_write(1, r);
		r = r | b;
		prog.push_back(rr_word(OP_OR, 16, 17));
		expect_write(1, r);
		r = r ^ b;
		prog.push_back(rr_word(OP_EOR, 16, 17));
		expect_write(1, r);
		r = ~r;
		prog.push_back(com_word(16));
		expect_write(1, r);
		// each op above is followed by its OUT
		for (int i = 0; i < 8; i++)
			prog.insert(3 + 2 * i, out_word(1, 16));
		prog.push_back(rr_word(OP_MOV, 18, 16));
		prog.push_back(out_word(1, 18));
		expect_write(1, r);
		k = byte_t'($urandom);
		r = byte_t'(int'(r) - int'(k));
		prog.push_back(imm_word(OP_SUBI, 16, k));
		prog.push_back(out_word(1, 16));
		expect_write(1, r);
		k = byte_t'($urandom);
		r = r | k;
		prog.push_back(imm_word(OP_ORI, 16, k));
		prog.push_back(out_word(1, 16));
		expect_write(1, r);
		k = byte_t'($urandom);
		r = r & k;
		prog.push_back(imm_word(OP_ANDI, 16, k));
		prog.push_back(out_word(1, 16));
		expect_write(1, r);
		prog.push_back(HALT);
		run_program("alu chain");
	endtask

	task automatic compare_flags_test();
		byte_t a;
		byte_t b;
		byte_t k;
		byte_t f1;
		byte_t f2;
		byte_t f3;
		a = byte_t'($urandom);
		b = byte_t'($urandom);
		k = byte_t'($urandom);
		f1 = sub_flags(a, b, 1'b0, 1'b0, 1'b0);
		f2 = sub_flags(a, k, 1'b0, 1'b0, 1'b0);
		// CPC picks up the carry and Z that CPI left behind
		f3 = sub_flags(b, a, f2[SREG_C], f2[SREG_Z], 1'b1);
		prog = '{imm_word(OP_LDI, 16, a), imm_word(OP_LDI, 17, b),
			rr_word(OP_CP, 16, 17), in_word(20, 6'h3F), out_word(2, 20),
			imm_word(OP_CPI, 16, k), in_word(21, 6'h3F), out_word(3, 21),
			rr_word(OP_CPC, 17, 16), in_word(20, 6'h3F), out_word(4, 20), HALT};
		expect_write(2, f1);
		expect_write(3, f2);
		expect_write(4, f3);
		run_program("compare flags");
	endtask

	task automatic branch_test();
		// equal compare sets Z, clears C; 0x80 - 1 sets V only
		prog = '{imm_word(OP_LDI, 16, 8'h11), imm_word(OP_LDI, 17, 8'h11),
			rr_word(OP_CP, 16, 17),
			branch_word(1'b0, 3'd1, 7'd1), out_word(6'h10, 16),
			branch_word(1'b1, 3'd0, 7'd1), out_word(6'h11, 16),
			branch_word(1'b0, 3'd0, 7'd1), out_word(6'h12, 16),
			branch_word(1'b1, 3'd1, 7'd1), out_word(6'h13, 17),
			rjmp_word(12'd2), out_word(6'h14, 16), out_word(6'h15, 16),
			imm_word(OP_LDI, 18, 8'h80), imm_word(OP_LDI, 19, 8'h01),
			rr_word(OP_CP, 18, 19),
			branch_word(1'b0, 3'd3, 7'd1), out_word(6'h16, 18),
			branch_word(1'b0, 3'd2, 7'd1), out_word(6'h17, 19), HALT};
		expect_write(6'h12, 8'h11);
		expect_write(6'h13, 8'h11);
		expect_write(6'h17, 8'h01);
		run_program("branches");
	endtask

	task automatic io_test();
		byte_t v;
		v = byte_t'($urandom);
		io_mem[10] = v;
		// SREG load of Z then a BRBS on Z
		prog = '{in_word(22, 6'h0A), out_word(6'h0B, 22),
			imm_word(OP_LDI, 23, 8'h02), out_word(6'h3F, 23),
			branch_word(1'b0, 3'd1, 7'd1), out_word(6'h0C, 23),
			out_word(6'h0D, 23), in_word(24, 6'h3F), out_word(6'h0E, 24), HALT};
		expect_write(6'h0B, v);
		expect_write(6'h0D, 8'h02);
		expect_write(6'h0E, 8'h02);
		run_program("io and sreg");
	endtask

	initial begin
		reset <= 1'b1;
		cdata <= '0;
		data_read <= '0;
		cycles = 0;
		void'($urandom(31986));
		for (int i = 0; i < 64; i++)
			io_mem[i] = byte_t'(i * 53 + 17);
		ldi_out_test();
		alu_chain_test();
		compare_flags_test();
		branch_test();
		io_test();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- files.f
risc8_pkg.sv
risc8_decode.sv
risc8_regs.sv
risc8_alu.sv
risc8_control.sv
risc8_core.sv
risc8_tb.sv

//--- run.sh
#!/bin/sh
# build and run the risc8 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f files.f --top-module risc8_tb -o risc8_sim
./obj_dir/risc8_sim
